// File: src/cpu_pkg.sv
package cpu_pkg;

  // memory geometry
  localparam int addr_w = 10;
  localparam int data_w = 16;
  localparam int page_w = 6;  // 64 words per page
  localparam int page_count = 16;

  typedef logic [addr_w-page_w-1:0] pnum_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] word_t;

  // register file
  localparam int reg_count = 32;
  typedef logic [$clog2(reg_count)-1:0] reg_t;

  // write-back flow control
  localparam int wb_credits = 4;
  localparam int credit_w = $clog2(wb_credits + 1);  // holds 0..wb_credits

  // opcodes sit in the high byte of the first instruction word
  localparam logic [7:0] op_jmp = 8'd1;
  localparam logic [7:0] op_ram2reg = 8'd2;
  localparam logic [7:0] op_reg2ram = 8'd3;
  localparam logic [7:0] op_num2reg = 8'd4;
  localparam logic [7:0] op_reg_plus = 8'd5;
  localparam logic [7:0] op_reg_minus = 8'd6;
  localparam logic [7:0] op_exit = 8'd17;

  typedef enum logic [3:0] {
    st_idle,       // waiting for run
    st_fetch1,     // request word 1
    st_fetch2,     // request word 2
    st_decode,     // word 1 arrives
    st_execute,    // word 2 arrives
    st_mem_wait,   // load in flight
    st_writeback,  // waits here for a credit
    st_halted
  } core_state_t;

endpackage

// File: src/mem_port_if.sv
`timescale 1ns/10ps

interface mem_port_if;

  logic               we;     // write strobe
  cpu_pkg::addr_t     waddr;  // physical write address
  cpu_pkg::word_t     wdata;
  logic               re;     // read strobe
  cpu_pkg::addr_t     raddr;  // physical read address
  cpu_pkg::word_t     rdata;  // registered read data

  modport ram (
    input  we,
    input  waddr,
    input  wdata,
    input  re,
    input  raddr,
    output rdata
  );

  modport ctrl (
    output we,
    output waddr,
    output wdata,
    output re,
    output raddr,
    input  rdata
  );

endinterface

// File: src/block_ram.sv
`timescale 1ns/10ps

module block_ram (
  input logic       clka,
  mem_port_if.ram   mem
);

  localparam int depth = 1 << cpu_pkg::addr_w;  // 1024 words

  cpu_pkg::word_t ram [depth];

  // write port
  always_ff @(posedge clka) begin
    if (mem.we) begin
      ram[mem.waddr] <= mem.wdata;
    end
  end

  // read data is held while re is low
  always_ff @(posedge clka) begin
    if (mem.re) begin
      mem.rdata <= ram[mem.raddr];
    end
  end

endmodule

// File: src/page_mmu.sv
`timescale 1ns/10ps

module page_mmu (
  input  logic            clka,
  input  logic            rst,
  input  logic            run,
  input  logic            load_en,
  input  cpu_pkg::addr_t  load_addr,
  input  cpu_pkg::word_t  load_data,
  input  logic            page_en,
  input  cpu_pkg::pnum_t  page_logical,
  input  cpu_pkg::pnum_t  page_physical,
  input  logic            core_rd,
  input  logic            core_wr,
  input  cpu_pkg::addr_t  core_addr,
  input  cpu_pkg::word_t  core_wdata,
  output cpu_pkg::word_t  core_rdata,
  mem_port_if.ctrl        mem
);

  cpu_pkg::pnum_t page_table [cpu_pkg::page_count];
  cpu_pkg::addr_t phys_addr;

  // page number swapped, offset kept
  assign phys_addr = {page_table[core_addr[cpu_pkg::addr_w-1:cpu_pkg::page_w]],
                      core_addr[cpu_pkg::page_w-1:0]};

  // the page table is only written while the loader owns the bus
  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < cpu_pkg::page_count; i++) begin
        page_table[i] <= cpu_pkg::pnum_t'(i);  // identity map
      end
    end else if (page_en && !run) begin
      page_table[page_logical] <= page_physical;
    end
  end

  // strobes to the RAM
  always_ff @(posedge clka) begin
    if (!rst) begin
      mem.we <= 1'b0;
      mem.re <= 1'b0;
    end else if (run) begin
      mem.we <= core_wr;
      mem.re <= core_rd;
    end else begin
      mem.we <= load_en;  // loader writes pass straight through
      mem.re <= 1'b0;
    end
  end

  // addresses and write data
  always_ff @(posedge clka) begin
    if (run) begin
      mem.waddr <= phys_addr;
      mem.wdata <= core_wdata;
    end else begin
      mem.waddr <= load_addr;  // untranslated
      mem.wdata <= load_data;
    end
    mem.raddr <= phys_addr;
  end

  assign core_rdata = mem.rdata;

endmodule

// File: src/cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
  input  logic            clka,
  input  logic            rst,
  input  logic            run,
  output logic            core_rd,
  output logic            core_wr,
  output cpu_pkg::addr_t  core_addr,
  output cpu_pkg::word_t  core_wdata,
  input  cpu_pkg::word_t  core_rdata,
  output logic            wb_valid,
  output cpu_pkg::reg_t   wb_reg,
  output cpu_pkg::word_t  wb_data,
  input  logic            wb_credit,
  output logic            halted
);

  cpu_pkg::core_state_t state;
  cpu_pkg::addr_t pc;
  cpu_pkg::word_t regs [cpu_pkg::reg_count];

  logic [7:0] op_q;  // opcode of current instruction
  cpu_pkg::reg_t reg_q;  // target register
  cpu_pkg::word_t result_q;  // value waiting for write-back
  cpu_pkg::word_t wb_value;

  logic [cpu_pkg::credit_w-1:0] credit_cnt;
  logic cred_take;

  // memory requests come straight from the state
  assign core_rd = (state == cpu_pkg::st_fetch1) || (state == cpu_pkg::st_fetch2) ||
                   (state == cpu_pkg::st_execute && op_q == cpu_pkg::op_ram2reg);
  assign core_wr = (state == cpu_pkg::st_execute) && (op_q == cpu_pkg::op_reg2ram);
  assign core_wdata = regs[reg_q];

  always_comb begin
    case (state)
      cpu_pkg::st_fetch1: core_addr = pc;
      cpu_pkg::st_fetch2: core_addr = pc + cpu_pkg::addr_t'(1);
      default:            core_addr = core_rdata[cpu_pkg::addr_w-1:0];  // operand word
    endcase
  end

  // RAM data stays put while no read is issued, so loads take it from the bus
  assign wb_value = (op_q == cpu_pkg::op_ram2reg) ? core_rdata : result_q;

  assign cred_take = (state == cpu_pkg::st_writeback) && (credit_cnt != '0);
  assign halted = (state == cpu_pkg::st_halted);

  // a return and a take can meet in one cycle
  always_ff @(posedge clka) begin
    if (!rst) begin
      credit_cnt <= cpu_pkg::credit_w'(cpu_pkg::wb_credits);
    end else begin
      credit_cnt <= credit_cnt + cpu_pkg::credit_w'(wb_credit)
                    - cpu_pkg::credit_w'(cred_take);
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= cpu_pkg::st_idle;
      pc <= '0;
      wb_valid <= 1'b0;
      for (int i = 0; i < cpu_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      wb_valid <= 1'b0;
      case (state)
        cpu_pkg::st_idle: begin
          if (run) begin
            state <= cpu_pkg::st_fetch1;
          end
        end
        cpu_pkg::st_fetch1: state <= cpu_pkg::st_fetch2;
        cpu_pkg::st_fetch2: begin
          pc <= pc + cpu_pkg::addr_t'(2);  // two-word instructions
          state <= cpu_pkg::st_decode;
        end
        cpu_pkg::st_decode: begin
          op_q <= core_rdata[15:8];
          reg_q <= core_rdata[$bits(cpu_pkg::reg_t)-1:0];  // upper bits ignored
          state <= cpu_pkg::st_execute;
        end
        cpu_pkg::st_execute: begin
          case (op_q)
            cpu_pkg::op_jmp: begin
              pc <= core_rdata[cpu_pkg::addr_w-1:0];
              state <= cpu_pkg::st_fetch1;
            end
            cpu_pkg::op_num2reg: begin
              result_q <= core_rdata;
              state <= cpu_pkg::st_writeback;
            end
            cpu_pkg::op_reg_plus: begin
              result_q <= regs[reg_q] + core_rdata;  // wraps
              state <= cpu_pkg::st_writeback;
            end
            cpu_pkg::op_reg_minus: begin
              result_q <= regs[reg_q] - core_rdata;
              state <= cpu_pkg::st_writeback;
            end
            cpu_pkg::op_ram2reg: state <= cpu_pkg::st_mem_wait;
            cpu_pkg::op_exit:    state <= cpu_pkg::st_halted;
            default:             state <= cpu_pkg::st_fetch1;  // store or unknown op
          endcase
        end
        cpu_pkg::st_mem_wait: state <= cpu_pkg::st_writeback;
        cpu_pkg::st_writeback: begin
          if (cred_take) begin
            regs[reg_q] <= wb_value;
            wb_valid <= 1'b1;
            wb_reg <= reg_q;
            wb_data <= wb_value;
            state <= cpu_pkg::st_fetch1;
          end
        end
        cpu_pkg::st_halted: state <= cpu_pkg::st_halted;  // until reset
        default:            state <= cpu_pkg::st_idle;
      endcase
    end
  end

endmodule

// File: src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic            clka,
  input  logic            rst,
  input  logic            run,
  input  logic            load_en,
  input  cpu_pkg::addr_t  load_addr,
  input  cpu_pkg::word_t  load_data,
  input  logic            page_en,
  input  cpu_pkg::pnum_t  page_logical,
  input  cpu_pkg::pnum_t  page_physical,
  output logic            wb_valid,
  output cpu_pkg::reg_t   wb_reg,
  output cpu_pkg::word_t  wb_data,
  input  logic            wb_credit,
  output logic            halted
);

  logic           core_rd;
  logic           core_wr;
  cpu_pkg::addr_t core_addr;  // logical
  cpu_pkg::word_t core_wdata;
  cpu_pkg::word_t core_rdata;

  mem_port_if ram_bus ();

  block_ram i_ram (
    .clka (clka),
    .mem  (ram_bus.ram)
  );

  page_mmu i_mmu (
    .clka          (clka),
    .rst           (rst),
    .run           (run),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .page_en       (page_en),
    .page_logical  (page_logical),
    .page_physical (page_physical),
    .core_rd       (core_rd),
    .core_wr       (core_wr),
    .core_addr     (core_addr),
    .core_wdata    (core_wdata),
    .core_rdata    (core_rdata),
    .mem           (ram_bus.ctrl)
  );

  cpu_core i_core (
    .clka       (clka),
    .rst        (rst),
    .run        (run),
    .core_rd    (core_rd),
    .core_wr    (core_wr),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_rdata (core_rdata),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .wb_credit  (wb_credit),
    .halted     (halted)
  );

endmodule

// File: bench/cpu_sva.sv
`timescale 1ns/10ps

module cpu_sva (
  input logic                           clka,
  input logic                           rst,
  input logic                           wb_valid,
  input logic                           halted,
  input logic [cpu_pkg::credit_w-1:0]   credit_cnt
);

  credit_max: assert property (@(posedge clka) disable iff (!rst)
    credit_cnt <= cpu_pkg::credit_w'(cpu_pkg::wb_credits))
    else $error("credit counter went above %0d", cpu_pkg::wb_credits);

  // pulse is registered, so look at the counter one cycle back
  credit_used: assert property (@(posedge clka) disable iff (!rst)
    wb_valid |-> $past(credit_cnt) != '0)
    else $error("wb_valid raised with no credit left");

  halted_sticky: assert property (@(posedge clka) disable iff (!rst)
    halted |=> halted)
    else $error("halted fell before reset");

endmodule

bind cpu_core cpu_sva i_sva (
  .clka       (clka),
  .rst        (rst),
  .wb_valid   (wb_valid),
  .halted     (halted),
  .credit_cnt (credit_cnt)
);

// File: bench/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

  localparam int trace_words = 256;
  localparam int settle_cycles = 100;  // quiet time after EXIT

  logic clka = 1'b0;
  logic rst;
  logic run;
  logic load_en;
  cpu_pkg::addr_t load_addr;
  cpu_pkg::word_t load_data;
  logic page_en;
  cpu_pkg::pnum_t page_logical;
  cpu_pkg::pnum_t page_physical;
  logic wb_valid;
  cpu_pkg::reg_t wb_reg;
  cpu_pkg::word_t wb_data;
  logic wb_credit = 1'b0;
  logic halted;

  logic [31:0] trace [trace_words];
  logic [31:0] lfsr = 32'h6a89f9de;
  int exp_reg [$];
  int exp_val [$];
  int exp_test [$];
  int due_q [$];  // cycle at which each held credit goes back
  int delay_base [8];
  int delay_bits [8];
  int errors [8];
  int exp_idx = 0;
  int cycle = 0;
  int wb_seen = 0;
  int credits_back = 0;
  bit trace_ready = 1'b0;

  cpu_top i_dut (.*);

  always #5 clka = ~clka;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clka);
    page_en = 1'b0;
    load_en = 1'b1;
    load_addr = cpu_pkg::addr_t'(addr);
    load_data = cpu_pkg::word_t'(data);
  endtask

  task automatic map_page(input logic [31:0] logical, input logic [31:0] physical);
    @(negedge clka);
    load_en = 1'b0;
    page_en = 1'b1;
    page_logical = cpu_pkg::pnum_t'(logical);
    page_physical = cpu_pkg::pnum_t'(physical);
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s with %0d errors", t, (errors[t] == 0) ? "passed" : "failed", errors[t]);
  endtask

  // outputs sampled first, then the credit line is driven
  always @(negedge clka) begin
    int t;
    int extra;
    cycle++;
    t = (exp_idx < exp_test.size()) ? exp_test[exp_idx] : 6;
    if (wb_valid === 1'b1) begin
      wb_seen++;
      if (wb_seen > cpu_pkg::wb_credits + credits_back) begin
        $display("write-back at %0t was sent without a credit", $time);
        errors[t]++;
      end
      if (exp_idx >= exp_test.size()) begin
        $display("unexpected write-back of r%0d at %0t after all expected ones", wb_reg, $time);
        errors[t]++;
      end else begin
        if (int'(wb_reg) != exp_reg[exp_idx] || int'(wb_data) != exp_val[exp_idx]) begin
          $display("Fail at %0t: test %0d got r%0d = %h, expected r%0d = %h", $time, t,
                   wb_reg, wb_data, exp_reg[exp_idx], exp_val[exp_idx]);
          errors[t]++;
        end
        exp_idx++;
        if (exp_idx == exp_test.size() || exp_test[exp_idx] != t) begin
          report_test(t);
        end
      end
      draw_bits(delay_bits[t], extra);
      due_q.push_back(cycle + delay_base[t] + extra);
    end
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      wb_credit = 1'b1;  // one-cycle return
      credits_back++;
    end else begin
      wb_credit = 1'b0;
    end
  end

  initial begin
    int k;
    int total;
    rst = 1'b0;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    page_en = 1'b0;
    page_logical = '0;
    page_physical = '0;
    for (int i = 0; i < 8; i++) begin
      delay_base[i] = 2;  // default return delay
      delay_bits[i] = 0;
      errors[i] = 0;
    end
    for (int i = 0; i < trace_words; i++) begin
      trace[i] = '0;
    end
    $readmemh("bench/cpu_trace.txt", trace);
    repeat (5) @(negedge clka);
    rst = 1'b1;
    k = 0;
    while (k + 4 <= trace_words && trace[k] != 0) begin
      case (trace[k])
        1: begin
          load_word(trace[k+1], trace[k+2]);
          load_word(trace[k+1] + 1, trace[k+3]);
        end
        2: load_word(trace[k+1], trace[k+2]);
        3: map_page(trace[k+1], trace[k+2]);
        4: begin
          delay_base[int'(trace[k+1])] = int'(trace[k+2]);
          delay_bits[int'(trace[k+1])] = int'(trace[k+3]);
        end
        5: begin
          exp_reg.push_back(int'(trace[k+1]));
          exp_val.push_back(int'(trace[k+2]));
          exp_test.push_back(int'(trace[k+3]));
        end
        default: begin
          $display("trace record %0d has an unknown kind %h", k / 4, trace[k]);
          errors[0]++;
        end
      endcase
      k += 4;
    end
    trace_ready = 1'b1;
    @(negedge clka);
    load_en = 1'b0;
    page_en = 1'b0;
    repeat (2) @(negedge clka);
    run = 1'b1;
    wait (exp_idx == exp_test.size());
    wait (halted === 1'b1);
    repeat (settle_cycles) @(negedge clka);  // monitor flags any late write-back
    if (halted !== 1'b1) begin
      $display("halted dropped during the quiet time after EXIT");
      errors[6]++;
    end
    report_test(6);
    total = 0;
    for (int i = 0; i < 8; i++) begin
      total += errors[i];
    end
    $display("%0d write-backs checked, %0d credits returned, %0d errors", exp_idx,
             credits_back, total);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (trace_ready);
    limit = 200 * exp_test.size() + 1000;
    repeat (limit) @(posedge clka);
    $display("watchdog expired after %0d cycles, the program did not finish", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: bench/cpu_trace.txt
// kind a b c: 1 = instruction (addr, word 1, word 2), 2 = data (addr, word), 3 = page (logical, physical)
// 4 = credit delay (test, base cycles, random bits), 5 = write-back (reg, value, test), 0 = end
1 000 0401 1234
1 002 0501 f000
1 004 0602 0005
1 006 0203 0045
1 008 0301 0090
1 00a 0204 0090
1 00c 0100 0010
1 00e 0405 dead
1 010 0406 0006
1 012 0607 0001
1 014 0507 0003
1 016 043f 7fff
1 018 051f 8001
1 01a 0506 0010
1 01c 1100 0000
2 245 beef 0
2 090 5555 0
3 1 9 0
3 2 c 0
4 5 14 4
5 01 1234 1
5 01 0234 1
5 02 fffb 1
5 03 beef 2
5 04 0234 3
5 06 0006 4
5 07 ffff 5
5 07 0002 5
5 1f 7fff 5
5 1f 0000 5
5 06 0016 5
0 0 0 0

// File: verilog.f
src/cpu_pkg.sv
src/mem_port_if.sv
src/block_ram.sv
src/page_mmu.sv
src/cpu_core.sv
src/cpu_top.sv
bench/cpu_sva.sv
bench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
